/* faux_sata_hd.f */
hdl/faux_sata_pkg.sv
hdl/fis_rx_if.sv
hdl/faux_hd_oob.sv
hdl/sata_link_rx.sv
hdl/h2d_reg_decoder.sv
hdl/sata_tx_merge.sv
hdl/faux_sata_hd.sv
tests/faux_sata_hd_sva.sv
tests/faux_sata_hd_tb.sv

/* hdl/faux_hd_oob.sv */
// Device-side OOB bring-up, answers COMRESET and COMWAKE then trains the link on ALIGN
`default_nettype none
`timescale 1ns/100ps

module faux_hd_oob (
  input  logic                  clk,
  input  logic                  rst_n,
  input  faux_sata_pkg::dword_t rx_din,
  input  logic                  rx_is_k,
  input  logic                  comm_reset_detect,
  input  logic                  comm_wake_detect,
  output logic                  tx_comm_reset,
  output logic                  tx_comm_wake,
  output logic                  tx_set_elec_idle,
  output logic                  phy_ready,
  output faux_sata_pkg::dword_t oob_dout,
  output logic                  oob_is_k
);
  import faux_sata_pkg::*;

  oob_state_e state;
  oob_state_e state_next;
  logic       rx_align;

  assign rx_align = rx_is_k && (rx_din == PRIM_ALIGN);

  always_comb begin
    state_next = state;
    // COMRESET restarts bring-up from any state
    if (comm_reset_detect) begin
      state_next = SEND_COMINIT;
    end else begin
      case (state)
        IDLE:         state_next = IDLE;
        SEND_COMINIT: state_next = AWAIT_WAKE;
        AWAIT_WAKE: begin
          if (comm_wake_detect) begin
            state_next = SEND_COMWAKE;
          end
        end
        SEND_COMWAKE: state_next = SEND_ALIGN;
        SEND_ALIGN: begin
          if (rx_align) begin
            state_next = READY;
          end
        end
        READY:        state_next = READY;
        default:      state_next = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // OOB bursts last one cycle each
  assign tx_comm_reset    = (state == SEND_COMINIT);
  assign tx_comm_wake     = (state == SEND_COMWAKE);
  assign tx_set_elec_idle = !((state == SEND_ALIGN) || (state == READY));
  assign phy_ready        = (state == READY);

  assign oob_dout = (state == SEND_ALIGN) ? PRIM_ALIGN : PRIM_SYNC;
  assign oob_is_k = 1'b1;

endmodule

`default_nettype wire

/* hdl/faux_sata_hd.sv */
// Top of the device-side SATA drive model, connect it to a host transceiver and a command sink
`default_nettype none
`timescale 1ns/100ps

module faux_sata_hd (
  input  logic                         clk,
  input  logic                         rst_n,
  input  faux_sata_pkg::dword_t        rx_din,
  input  logic [3:0]                   rx_is_k,
  output faux_sata_pkg::dword_t        tx_dout,
  output logic [3:0]                   tx_is_k,
  output logic                         tx_set_elec_idle,
  input  logic                         comm_reset_detect,
  input  logic                         comm_wake_detect,
  output logic                         tx_comm_reset,
  output logic                         tx_comm_wake,
  output logic                         phy_ready,
  output logic                         cmd_req,
  input  logic                         cmd_ack,
  output logic [7:0]                   cmd_command,
  output logic [15:0]                  cmd_features,
  output logic [7:0]                   cmd_device,
  output faux_sata_pkg::lba_t          cmd_lba,
  output faux_sata_pkg::sector_count_t cmd_sector_count
);
  import faux_sata_pkg::*;

  dword_t oob_dout;
  logic   oob_is_k;
  dword_t link_dout;
  logic   link_is_k;
  logic   rx_any_k;

  // Any control byte marks the dword as non-data for the link layer
  assign rx_any_k = |rx_is_k;

  fis_rx_if fis (.clk(clk));

  faux_hd_oob u_oob (
    .clk               (clk),
    .rst_n             (rst_n),
    .rx_din            (rx_din),
    .rx_is_k           (rx_is_k[0]),
    .comm_reset_detect (comm_reset_detect),
    .comm_wake_detect  (comm_wake_detect),
    .tx_comm_reset     (tx_comm_reset),
    .tx_comm_wake      (tx_comm_wake),
    .tx_set_elec_idle  (tx_set_elec_idle),
    .phy_ready         (phy_ready),
    .oob_dout          (oob_dout),
    .oob_is_k          (oob_is_k)
  );

  sata_link_rx u_link (
    .clk       (clk),
    .rst_n     (rst_n),
    .phy_ready (phy_ready),
    .rx_din    (rx_din),
    .rx_is_k   (rx_any_k),
    .link_dout (link_dout),
    .link_is_k (link_is_k),
    .fis       (fis.link)
  );

  h2d_reg_decoder u_dec (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_ack          (cmd_ack),
    .fis              (fis.decoder),
    .cmd_req          (cmd_req),
    .cmd_command      (cmd_command),
    .cmd_features     (cmd_features),
    .cmd_device       (cmd_device),
    .cmd_lba          (cmd_lba),
    .cmd_sector_count (cmd_sector_count)
  );

  sata_tx_merge u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .phy_ready (phy_ready),
    .oob_dout  (oob_dout),
    .oob_is_k  (oob_is_k),
    .link_dout (link_dout),
    .link_is_k (link_is_k),
    .tx_dout   (tx_dout),
    .tx_is_k   (tx_is_k)
  );

endmodule

`default_nettype wire

/* hdl/faux_sata_pkg.sv */
// Primitive codes, FIS layouts and CRC helper shared by the device-side SATA model
`default_nettype none

package faux_sata_pkg;

  typedef logic [31:0] dword_t;

  // Link primitives with K28.x in byte 0
  localparam dword_t PRIM_ALIGN = 32'h7B4A4ABC;
  localparam dword_t PRIM_SYNC  = 32'hB5B5957C;
  localparam dword_t PRIM_X_RDY = 32'h5757B57C;
  localparam dword_t PRIM_R_RDY = 32'h4A4A957C;
  localparam dword_t PRIM_SOF   = 32'h3737B57C;
  localparam dword_t PRIM_EOF   = 32'hD5D5B57C;
  localparam dword_t PRIM_R_IP  = 32'h5555B57C;
  localparam dword_t PRIM_WTRM  = 32'h5858B57C;
  localparam dword_t PRIM_R_OK  = 32'h3535B57C;
  localparam dword_t PRIM_R_ERR = 32'h5656B57C;

  // Frame CRC seed and generator
  localparam dword_t CRC_INIT = 32'h52325032;
  localparam dword_t CRC_POLY = 32'h04C11DB7;

  localparam logic [7:0] FIS_TYPE_REG_H2D = 8'h27;
  localparam logic [2:0] H2D_REG_DWORDS   = 3'd5;

  // Dwords between the starts of two ALIGN pairs
  localparam logic [8:0] ALIGN_INTERVAL = 9'd256;

  typedef logic [47:0] lba_t;
  typedef logic [15:0] sector_count_t;

  typedef enum logic [3:0] {
    IDLE,
    SEND_COMINIT,
    AWAIT_WAKE,
    SEND_COMWAKE,
    SEND_ALIGN,
    READY
  } oob_state_e;

  // First dword of a FIS, fis_type sits in byte 0
  typedef union packed {
    dword_t raw;
    struct packed {
      logic [7:0] features;
      logic [7:0] command;
      logic [7:0] flags;    // Bit 7 is the command bit, [3:0] the PM port
      logic [7:0] fis_type;
    } fields;
  } fis_dw0_u;

  // One dword folded into the CRC, msb first
  function automatic dword_t crc_step(input dword_t crc, input dword_t data);
    dword_t c;
    c = crc;
    for (int i = 31; i >= 0; i--) begin
      if (c[31] ^ data[i]) begin
        c = (c << 1) ^ CRC_POLY;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

endpackage

`default_nettype wire

/* hdl/fis_rx_if.sv */
// Carries received FIS data dwords from the link receiver down to the FIS decoder
`default_nettype none
`timescale 1ns/100ps

interface fis_rx_if (input logic clk);
  import faux_sata_pkg::*;

  logic   dw_valid;
  dword_t dw;
  logic   sof;
  logic   frame_done;
  logic   crc_ok;

  // No back-pressure, the decoder only listens
  modport link (
    input  clk,
    output dw_valid, dw, sof, frame_done, crc_ok
  );

  modport decoder (
    input clk,
    input dw_valid, dw, sof, frame_done, crc_ok
  );

endinterface

`default_nettype wire

/* hdl/h2d_reg_decoder.sv */
// Decodes a Register Host-to-Device FIS and hands the command over by a four-phase handshake
`default_nettype none
`timescale 1ns/100ps

module h2d_reg_decoder (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_ack,
  fis_rx_if.decoder                    fis,
  output logic                         cmd_req,
  output logic [7:0]                   cmd_command,
  output logic [15:0]                  cmd_features,
  output logic [7:0]                   cmd_device,
  output faux_sata_pkg::lba_t          cmd_lba,
  output faux_sata_pkg::sector_count_t cmd_sector_count
);
  import faux_sata_pkg::*;

  fis_dw0_u      dw0;
  logic [7:0]    device;
  logic [7:0]    features_exp;
  lba_t          lba;
  sector_count_t sector_count;
  logic [2:0]    dw_cnt;
  logic [2:0]    dw_idx;
  logic          take_cmd;

  assign dw_idx = fis.sof ? 3'd0 : dw_cnt;

  // Dwords past the register FIS length are ignored
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dw_cnt <= '0;
    end else if (fis.dw_valid && (dw_idx < H2D_REG_DWORDS)) begin
      dw_cnt <= dw_idx + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (fis.dw_valid) begin
      case (dw_idx)
        3'd0: dw0.raw <= fis.dw;
        3'd1: begin
          lba[23:0] <= fis.dw[23:0];
          device    <= fis.dw[31:24];
        end
        3'd2: begin
          lba[47:24]   <= fis.dw[23:0];
          features_exp <= fis.dw[31:24];
        end
        3'd3: sector_count <= fis.dw[15:0];
        default: ;
      endcase
    end
  end

  // Frames that finish while a command is outstanding are dropped
  assign take_cmd = fis.frame_done && fis.crc_ok &&
                    (dw0.fields.fis_type == FIS_TYPE_REG_H2D) && dw0.fields.flags[7] &&
                    !cmd_req && !cmd_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_req <= 1'b0;
    end else if (take_cmd) begin
      cmd_req <= 1'b1;
    end else if (cmd_ack) begin
      cmd_req <= 1'b0;
    end
  end

  // Fields frozen for the whole request phase
  always_ff @(posedge clk) begin
    if (take_cmd) begin
      cmd_command      <= dw0.fields.command;
      cmd_features     <= {features_exp, dw0.fields.features};
      cmd_device       <= device;
      cmd_lba          <= lba;
      cmd_sector_count <= sector_count;
    end
  end

endmodule

`default_nettype wire

/* hdl/sata_link_rx.sv */
// Receive link layer, frames inbound dwords, checks the CRC and picks the reply primitive
`default_nettype none
`timescale 1ns/100ps

module sata_link_rx (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  phy_ready,
  input  faux_sata_pkg::dword_t rx_din,
  input  logic                  rx_is_k,
  output faux_sata_pkg::dword_t link_dout,
  output logic                  link_is_k,
  fis_rx_if.link                fis
);
  import faux_sata_pkg::*;

  enum logic [2:0] {RX_IDLE, RX_RDY, RX_RECV, RX_CHECK, RX_REPLY} state;

  dword_t crc;
  logic   first_dw;
  logic   crc_good;
  logic   rx_data;
  logic   rx_x_rdy;
  logic   rx_sof;
  logic   rx_eof;
  logic   rx_wtrm;
  logic   rx_sync;

  assign rx_data  = !rx_is_k;
  assign rx_x_rdy = rx_is_k && (rx_din == PRIM_X_RDY);
  assign rx_sof   = rx_is_k && (rx_din == PRIM_SOF);
  assign rx_eof   = rx_is_k && (rx_din == PRIM_EOF);
  assign rx_wtrm  = rx_is_k && (rx_din == PRIM_WTRM);
  assign rx_sync  = rx_is_k && (rx_din == PRIM_SYNC);

  // Residue is zero once the trailing CRC dword is folded in
  assign crc_good   = (crc == '0);
  assign fis.crc_ok = crc_good;
  assign link_is_k  = 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= RX_IDLE;
      link_dout      <= PRIM_SYNC;
      crc            <= CRC_INIT;
      first_dw       <= 1'b0;
      fis.dw_valid   <= 1'b0;
      fis.sof        <= 1'b0;
      fis.frame_done <= 1'b0;
    end else if (!phy_ready) begin
      state          <= RX_IDLE;
      link_dout      <= PRIM_SYNC;
      first_dw       <= 1'b0;
      fis.dw_valid   <= 1'b0;
      fis.sof        <= 1'b0;
      fis.frame_done <= 1'b0;
    end else begin
      fis.dw_valid   <= 1'b0;
      fis.sof        <= 1'b0;
      fis.frame_done <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (rx_x_rdy) begin
            state     <= RX_RDY;
            link_dout <= PRIM_R_RDY;
          end
        end
        RX_RDY: begin
          if (rx_sof) begin
            state     <= RX_RECV;
            link_dout <= PRIM_R_IP;
            crc       <= CRC_INIT;
            first_dw  <= 1'b1;
          end else if (rx_sync) begin
            state     <= RX_IDLE;
            link_dout <= PRIM_SYNC;
          end
        end
        RX_RECV: begin
          // ALIGN and other primitives inside the frame are skipped
          if (rx_data) begin
            crc          <= crc_step(crc, rx_din);
            first_dw     <= 1'b0;
            fis.dw_valid <= 1'b1;
            fis.sof      <= first_dw;
          end else if (rx_eof) begin
            state          <= RX_CHECK;
            fis.frame_done <= 1'b1;
          end
        end
        RX_CHECK: begin
          if (rx_wtrm) begin
            state     <= RX_REPLY;
            link_dout <= crc_good ? PRIM_R_OK : PRIM_R_ERR;
          end else if (rx_sync) begin
            state     <= RX_IDLE;
            link_dout <= PRIM_SYNC;
          end
        end
        RX_REPLY: begin
          // Status held until the host drops back to SYNC
          if (rx_sync) begin
            state     <= RX_IDLE;
            link_dout <= PRIM_SYNC;
          end
        end
        default: begin
          state     <= RX_IDLE;
          link_dout <= PRIM_SYNC;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == RX_RECV) && rx_data) begin
      fis.dw <= rx_din;
    end
  end

endmodule

`default_nettype wire

/* hdl/sata_tx_merge.sv */
// Picks bring-up or link traffic for the transmitter and inserts the periodic ALIGN pair
`default_nettype none
`timescale 1ns/100ps

module sata_tx_merge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  phy_ready,
  input  faux_sata_pkg::dword_t oob_dout,
  input  logic                  oob_is_k,
  input  faux_sata_pkg::dword_t link_dout,
  input  logic                  link_is_k,
  output faux_sata_pkg::dword_t tx_dout,
  output logic [3:0]            tx_is_k
);
  import faux_sata_pkg::*;

  logic [$clog2(ALIGN_INTERVAL)-1:0] align_cnt;
  logic                              align_slot;
  dword_t                            sel_dout;
  logic                              sel_is_k;
  logic                              is_k_q;

  // Last two counts of each interval carry ALIGN
  assign align_slot = phy_ready && ({1'b0, align_cnt} >= (ALIGN_INTERVAL - 9'd2));

  always_comb begin
    if (!phy_ready) begin
      sel_dout = oob_dout;
      sel_is_k = oob_is_k;
    end else if (align_slot) begin
      sel_dout = PRIM_ALIGN;
      sel_is_k = 1'b1;
    end else begin
      sel_dout = link_dout;
      sel_is_k = link_is_k;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      align_cnt <= '0;
      tx_dout   <= PRIM_SYNC;
      is_k_q    <= 1'b1;
    end else begin
      align_cnt <= phy_ready ? align_cnt + 1'b1 : '0;
      tx_dout   <= sel_dout;
      is_k_q    <= sel_is_k;
    end
  end

  assign tx_is_k = {3'b000, is_k_q};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module faux_sata_hd_tb \
  -f faux_sata_hd.f -o sim_faux_sata_hd > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_faux_sata_hd > sim.log 2>&1
grep -qx '>>> PASS' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* tests/faux_sata_hd_sva.sv */
// Protocol assertions on the drive model top level that bind attaches to every faux_sata_hd
`default_nettype none
`timescale 1ns/100ps

module faux_sata_hd_sva (
  input logic                         clk,
  input logic                         rst_n,
  input logic [3:0]                   tx_is_k,
  input logic                         tx_comm_reset,
  input logic                         tx_comm_wake,
  input logic                         cmd_req,
  input logic                         cmd_ack,
  input logic [7:0]                   cmd_command,
  input logic [15:0]                  cmd_features,
  input logic [7:0]                   cmd_device,
  input faux_sata_pkg::lba_t          cmd_lba,
  input faux_sata_pkg::sector_count_t cmd_sector_count
);
  logic [95:0] fields;
  int          fail_count = 0;

  assign fields = {cmd_command, cmd_features, cmd_device, cmd_lba, cmd_sector_count};

  // Only byte 0 of a dword ever carries a control code
  a_is_k_upper: assert property (@(posedge clk) disable iff (!rst_n) tx_is_k[3:1] == 3'b000)
    else begin
      fail_count++;
      $error("tx_is_k upper bits set");
    end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_req && !cmd_ack |=> cmd_req)
    else begin
      fail_count++;
      $error("cmd_req dropped before cmd_ack");
    end

  a_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_req |=> $stable(fields))
    else begin
      fail_count++;
      $error("command fields changed while cmd_req was high");
    end

  a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_req) |-> !$past(cmd_ack))
    else begin
      fail_count++;
      $error("cmd_req rose while cmd_ack was high");
    end

  a_reset_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    tx_comm_reset |=> !tx_comm_reset)
    else begin
      fail_count++;
      $error("tx_comm_reset longer than one cycle");
    end

  a_wake_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    tx_comm_wake |=> !tx_comm_wake)
    else begin
      fail_count++;
      $error("tx_comm_wake longer than one cycle");
    end

endmodule

bind faux_sata_hd faux_sata_hd_sva u_sva (.*);

`default_nettype wire

/* tests/faux_sata_hd_tb.sv */
// Top testbench that drives the drive model through bring-up, frames, commands and ALIGN spacing
`default_nettype none
`timescale 1ns/100ps

module faux_sata_hd_tb;
  import faux_sata_pkg::*;

  localparam logic [31:0] LFSR_SEED      = 32'hc7ebf19c;
  localparam int          TIMEOUT_CYCLES = 4000;

  logic          clk;
  logic          rst_n;
  dword_t        rx_din;
  logic [3:0]    rx_is_k;
  dword_t        tx_dout;
  logic [3:0]    tx_is_k;
  logic          tx_set_elec_idle;
  logic          comm_reset_detect;
  logic          comm_wake_detect;
  logic          tx_comm_reset;
  logic          tx_comm_wake;
  logic          phy_ready;
  logic          cmd_req;
  logic          cmd_ack;
  logic [7:0]    cmd_command;
  logic [15:0]   cmd_features;
  logic [7:0]    cmd_device;
  lba_t          cmd_lba;
  sector_count_t cmd_sector_count;

  int          errors;
  int          checks;
  int          tests;
  int          cycles;
  logic [31:0] lfsr;
  string       test_name;
  dword_t      frame_q[$];
  logic        saw_r_ip;
  logic        saw_r_ok;
  logic        saw_r_err;
  logic        saw_req;
  logic [7:0]  exp_command;
  logic [15:0] exp_features;
  logic [7:0]  exp_device;
  lba_t        exp_lba;
  logic [15:0] exp_count;
  logic        align_seen[1024];
  int          starts[$];

  faux_sata_hd dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic get_rand(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_eq(input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("FAILED %s expected %h actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error in %s: %s", test_name, what);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Step and note what the drive answered
  task automatic step_watch();
    step();
    if (tx_is_k[0] && tx_dout == PRIM_R_IP) saw_r_ip = 1'b1;
    if (tx_is_k[0] && tx_dout == PRIM_R_OK) saw_r_ok = 1'b1;
    if (tx_is_k[0] && tx_dout == PRIM_R_ERR) saw_r_err = 1'b1;
    if (cmd_req) saw_req = 1'b1;
  endtask

  task automatic drive_prim(input dword_t p);
    rx_din  = p;
    rx_is_k = 4'b0001;
  endtask

  task automatic drive_data(input dword_t d);
    rx_din  = d;
    rx_is_k = 4'b0000;
  endtask

  task automatic finish_test();
    tests++;
    $display("Test %s finished, %0d errors so far", test_name, errors);
  endtask

  task automatic bring_up();
    comm_reset_detect = 1'b1;
    step();
    comm_reset_detect = 1'b0;
    check_eq(1, tx_comm_reset);
    check_eq(0, phy_ready);
    check_eq(1, tx_set_elec_idle);
    step();
    check_eq(0, tx_comm_reset);
    comm_wake_detect = 1'b1;
    step();
    comm_wake_detect = 1'b0;
    check_eq(1, tx_comm_wake);
    step();
    check_eq(0, tx_comm_wake);
    check_eq(0, tx_set_elec_idle);
    step();
    check_eq(PRIM_ALIGN, tx_dout);
    drive_prim(PRIM_ALIGN);
    step();
    drive_prim(PRIM_SYNC);
    check_eq(1, phy_ready);
    step();
  endtask

  // Sends frame_q with its CRC appended so the receiver residue ends at zero
  task automatic send_frame(input logic bad_crc);
    dword_t crc;
    crc = CRC_INIT;
    saw_r_ip  = 1'b0;
    saw_r_ok  = 1'b0;
    saw_r_err = 1'b0;
    saw_req   = 1'b0;
    drive_prim(PRIM_X_RDY);
    step_watch();
    step_watch();
    check_true(tx_dout == PRIM_R_RDY || tx_dout == PRIM_ALIGN, "no R_RDY two cycles after X_RDY");
    step_watch();
    step_watch();
    drive_prim(PRIM_SOF);
    step_watch();
    foreach (frame_q[i]) begin
      crc = crc_step(crc, frame_q[i]);
      drive_data(frame_q[i]);
      step_watch();
    end
    drive_data(bad_crc ? (crc ^ 32'h1) : crc);
    step_watch();
    drive_prim(PRIM_EOF);
    step_watch();
    drive_prim(PRIM_WTRM);
    repeat (5) step_watch();
    drive_prim(PRIM_SYNC);
    repeat (6) step_watch();
  endtask

  task automatic build_fis(input logic [7:0] ftype, input logic cmd_bit);
    logic [31:0] r;
    get_rand(8, r);
    exp_command = r[7:0];
    get_rand(16, r);
    exp_features = r[15:0];
    get_rand(8, r);
    exp_device = r[7:0];
    get_rand(24, r);
    exp_lba[23:0] = r[23:0];
    get_rand(24, r);
    exp_lba[47:24] = r[23:0];
    get_rand(16, r);
    exp_count = r[15:0];
    frame_q = {};
    frame_q.push_back({exp_features[7:0], exp_command, cmd_bit, 7'h00, ftype});
    frame_q.push_back({exp_device, exp_lba[23:0]});
    frame_q.push_back({exp_features[15:8], exp_lba[47:24]});
    frame_q.push_back({16'h0000, exp_count});
    frame_q.push_back(32'h00000000);
  endtask

  task automatic wait_req();
    int n;
    n = 0;
    while (!cmd_req && n < 20) begin
      step();
      n++;
    end
    check_true(cmd_req, "cmd_req did not rise after a valid register FIS");
  endtask

  task automatic check_fields();
    check_eq(exp_command, cmd_command);
    check_eq(exp_features, cmd_features);
    check_eq(exp_device, cmd_device);
    check_eq(exp_lba, cmd_lba);
    check_eq(exp_count, cmd_sector_count);
  endtask

  // Drive side of the four-phase handshake
  task automatic ack_cmd();
    int n;
    n = 0;
    cmd_ack = 1'b1;
    while (cmd_req && n < 20) begin
      step();
      n++;
    end
    check_true(!cmd_req, "cmd_req stayed high after cmd_ack");
    cmd_ack = 1'b0;
    step();
  endtask

  task automatic expect_no_req();
    repeat (8) step_watch();
    check_true(!saw_req, "cmd_req raised for a frame that should be rejected");
  endtask

  initial begin
    errors = 0;
    checks = 0;
    tests  = 0;
    cycles = 0;
    lfsr   = LFSR_SEED;
    rst_n  = 1'b0;
    rx_din = PRIM_SYNC;
    rx_is_k = 4'b0001;
    comm_reset_detect = 1'b0;
    comm_wake_detect  = 1'b0;
    cmd_ack = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "bring_up";
    check_eq(1, tx_set_elec_idle);
    check_eq(0, phy_ready);
    check_eq(PRIM_SYNC, tx_dout);
    check_eq(4'b0001, tx_is_k);
    bring_up();
    finish_test();

    test_name = "link_handshake";
    frame_q = {32'h11223344, 32'h55667788};
    send_frame(1'b0);
    check_true(saw_r_ip, "no R_IP while the frame streamed");
    check_true(saw_r_ok, "no R_OK after a frame with a good CRC");
    finish_test();

    test_name = "reg_fis_decode";
    for (int k = 0; k < 2; k++) begin
      build_fis(FIS_TYPE_REG_H2D, 1'b1);
      send_frame(1'b0);
      wait_req();
      check_fields();
      ack_cmd();
    end
    finish_test();

    test_name = "rejection";
    build_fis(FIS_TYPE_REG_H2D, 1'b1);
    send_frame(1'b1);
    check_true(saw_r_err, "no R_ERR after a corrupted CRC");
    expect_no_req();
    build_fis(8'h34, 1'b1);
    send_frame(1'b0);
    expect_no_req();
    build_fis(FIS_TYPE_REG_H2D, 1'b0);
    send_frame(1'b0);
    expect_no_req();
    build_fis(FIS_TYPE_REG_H2D, 1'b1);
    send_frame(1'b0);
    wait_req();
    frame_q[0][23:16] = ~exp_command;
    send_frame(1'b0);
    check_fields();
    ack_cmd();
    saw_req = 1'b0;
    expect_no_req();
    finish_test();

    test_name = "align_insertion";
    drive_prim(PRIM_SYNC);
    for (int i = 0; i < 1024; i++) begin
      step();
      align_seen[i] = tx_is_k[0] && (tx_dout == PRIM_ALIGN);
    end
    for (int i = 1; i < 1024; i++) begin
      if (align_seen[i] && !align_seen[i-1]) starts.push_back(i);
    end
    check_true(starts.size() >= 3, "too few ALIGN pairs in 1024 dwords");
    foreach (starts[j]) begin
      if (starts[j] + 1 < 1024) check_true(align_seen[starts[j] + 1], "lone ALIGN");
      if (starts[j] + 2 < 1024) check_true(!align_seen[starts[j] + 2], "ALIGN run over two");
      if (j > 0) check_eq(256, starts[j] - starts[j-1]);
    end
    finish_test();

    test_name = "re_bring_up";
    bring_up();
    finish_test();

    errors += dut.u_sva.fail_count;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
